/* decode_stage.f */
+incdir+tb
src/decode_pkg.sv
src/rv32_decoder.sv
src/group_hazard.sv
src/replay_buffer.sv
src/issue_reg.sv
src/decode_stage.sv
tb/decode_stage_tb.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
RTL_TOP   ?= decode_stage
FILELIST  ?= decode_stage.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* tb/decode_encode.svh */
// RV32 encoding helpers for the decode stage testbench
// assemble instruction words and build expected lane controls
`ifndef DECODE_ENCODE_SVH
`define DECODE_ENCODE_SVH

// flag bits in the order valid illegal halt csr rd_mem wr_mem cond uncond
localparam logic [7:0] F_VALID = 8'h80;
localparam logic [7:0] F_ILLEGAL = 8'h40;
localparam logic [7:0] F_HALT = 8'h20;
localparam logic [7:0] F_CSR = 8'h10;
localparam logic [7:0] F_RDMEM = 8'h08;
localparam logic [7:0] F_WRMEM = 8'h04;
localparam logic [7:0] F_COND = 8'h02;
localparam logic [7:0] F_UNCOND = 8'h01;

function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic inst_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic inst_t enc_j(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// expected controls, source indices are the raw rs fields
function automatic lane_ctrl_t exp_ctrl(inst_t inst, logic [7:0] flags, opa_sel_e opa,
                                        opb_sel_e opb, alu_func_e fn, reg_idx_t dest);
    lane_ctrl_t c;
    c.valid         = flags[7];
    c.illegal       = flags[6];
    c.halt          = flags[5];
    c.csr_op        = flags[4];
    c.rd_mem        = flags[3];
    c.wr_mem        = flags[2];
    c.cond_branch   = flags[1];
    c.uncond_branch = flags[0];
    c.opa           = opa;
    c.opb           = opb;
    c.alu_func      = fn;
    c.dest_idx      = dest;
    c.rs1_idx       = inst[19:15];
    c.rs2_idx       = inst[24:20];
    return c;
endfunction

`endif

/* tb/decode_stage_tb.sv */
// decode stage testbench
// directed tests for decode, intra-group split and back-pressure,
// with a combinational register-file model
module decode_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    localparam int ISSUE_WIDTH = 2;
    localparam int N_TESTS = 5;

    logic clk = 1'b0;
    logic arst_n;
    logic in_valid;
    fetch_lane_t [ISSUE_WIDTH-1:0] in_lanes;
    logic in_ready;
    reg_idx_t [ISSUE_WIDTH-1:0] rf_rs1_idx;
    reg_idx_t [ISSUE_WIDTH-1:0] rf_rs2_idx;
    xlen_t [ISSUE_WIDTH-1:0] rf_rs1_val;
    xlen_t [ISSUE_WIDTH-1:0] rf_rs2_val;
    logic out_ready;
    logic out_valid;
    issue_lane_t [ISSUE_WIDTH-1:0] out_lanes;

    integer seed = 17062;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_start_errs;

    `include "decode_encode.svh"

    always #20 clk = ~clk;

    decode_stage #(.ISSUE_WIDTH(ISSUE_WIDTH)) DUT (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_lanes(in_lanes),
        .in_ready(in_ready), .rf_rs1_idx(rf_rs1_idx), .rf_rs2_idx(rf_rs2_idx),
        .rf_rs1_val(rf_rs1_val), .rf_rs2_val(rf_rs2_val), .out_ready(out_ready),
        .out_valid(out_valid), .out_lanes(out_lanes)
    );

    // register file model, value is index times 0x01010101
    function automatic xlen_t rf_value(reg_idx_t idx);
        return xlen_t'(idx) * 32'h0101_0101;
    endfunction

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            rf_rs1_val[i] = rf_value(rf_rs1_idx[i]);
            rf_rs2_val[i] = rf_value(rf_rs2_idx[i]);
        end
    end

    // word-aligned random pc
    function automatic fetch_lane_t fetch_lane(logic v, inst_t inst);
        fetch_lane_t l;
        l.valid = v;
        l.pc    = xlen_t'($random(seed)) & ~xlen_t'(3);
        l.inst  = inst;
        return l;
    endfunction

    // --------------------------------------------------
    // drive and sample helpers
    // --------------------------------------------------
    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_group(input fetch_lane_t [ISSUE_WIDTH-1:0] lanes);
        int waited;
        waited   = 0;
        in_lanes = lanes;
        in_valid = 1'b1;
        #1;
        while (!in_ready && waited < 200) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!in_ready) begin
            $display("in_ready never went high at %0t", $time);
            errors++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic collect(output issue_lane_t [ISSUE_WIDTH-1:0] got);
        int waited;
        waited = 0;
        while (!out_valid && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            $display("out_valid never went high at %0t", $time);
            errors++;
        end
        got = out_lanes;
        @(negedge clk);
    endtask

    task automatic check_lane(input int idx, input issue_lane_t got, input lane_ctrl_t exp,
                              input fetch_lane_t src);
        checks++;
        if (got.ctrl !== exp) begin
            $display("FAIL %0t: lane %0d ctrl %h, expected %h", $time, idx, got.ctrl, exp);
            errors++;
        end
        if (got.pc !== src.pc || got.inst !== src.inst) begin
            $display("FAIL %0t: lane %0d pc/inst %h/%h, expected %h/%h", $time, idx,
                     got.pc, got.inst, src.pc, src.inst);
            errors++;
        end
        if (got.rs1_value !== rf_value(exp.rs1_idx) ||
            got.rs2_value !== rf_value(exp.rs2_idx)) begin
            $display("FAIL %0t: lane %0d register values %h %h", $time, idx,
                     got.rs1_value, got.rs2_value);
            errors++;
        end
    endtask

    task automatic start_test();
        test_start_errs = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errs) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - test_start_errs);
        end
    endtask

    // one group with no split, both lanes checked
    task automatic run_pair(input inst_t i0, input inst_t i1, input logic v1,
                            input lane_ctrl_t e0, input lane_ctrl_t e1);
        fetch_lane_t [ISSUE_WIDTH-1:0] lanes;
        issue_lane_t [ISSUE_WIDTH-1:0] got;
        lanes[0] = fetch_lane(1'b1, i0);
        lanes[1] = fetch_lane(v1, i1);
        send_group(lanes);
        collect(got);
        check_lane(0, got[0], e0, lanes[0]);
        check_lane(1, got[1], e1, lanes[1]);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic alu_decode();
        inst_t a;
        inst_t b;
        start_test();
        a = enc_i(12'd100, 5'd1, F3_ADD, 5'd5, OP_IMM);
        b = enc_r(F7_ALT, 5'd3, 5'd2, F3_ADD, 5'd6);
        run_pair(a, b, 1'b1, exp_ctrl(a, F_VALID, OPA_RS1, OPB_I_IMM, ALU_ADD, 5'd5),
                 exp_ctrl(b, F_VALID, OPA_RS1, OPB_RS2, ALU_SUB, 5'd6));
        a = enc_i(12'd5, 5'd4, F3_SLTU, 5'd7, OP_IMM);
        b = enc_i(12'h403, 5'd9, F3_SRL, 5'd8, OP_IMM);
        run_pair(a, b, 1'b1, exp_ctrl(a, F_VALID, OPA_RS1, OPB_I_IMM, ALU_SLTU, 5'd7),
                 exp_ctrl(b, F_VALID, OPA_RS1, OPB_I_IMM, ALU_SRA, 5'd8));
        a = enc_r(F7_MULDIV, 5'd12, 5'd11, 3'b011, 5'd10);
        b = enc_i(12'd1, 5'd10, F3_ADD, 5'd13, OP_IMM);
        run_pair(a, b, 1'b0, exp_ctrl(a, F_VALID, OPA_RS1, OPB_RS2, ALU_MULHU, 5'd10),
                 exp_ctrl(b, 8'h00, OPA_RS1, OPB_RS2, ALU_ADD, 5'd0));
        end_test("alu_decode");
    endtask

    task automatic flow_mem_decode();
        inst_t a;
        inst_t b;
        start_test();
        a = enc_u(20'h12345, 5'd1, OP_LUI);
        b = enc_u(20'h00001, 5'd2, OP_AUIPC);
        run_pair(a, b, 1'b1, exp_ctrl(a, F_VALID, OPA_ZERO, OPB_U_IMM, ALU_ADD, 5'd1),
                 exp_ctrl(b, F_VALID, OPA_PC, OPB_U_IMM, ALU_ADD, 5'd2));
        a = enc_j(21'd8, 5'd3);
        b = enc_i(12'd0, 5'd5, 3'b000, 5'd4, OP_JALR);
        run_pair(a, b, 1'b1,
                 exp_ctrl(a, F_VALID | F_UNCOND, OPA_PC, OPB_J_IMM, ALU_ADD, 5'd3),
                 exp_ctrl(b, F_VALID | F_UNCOND, OPA_RS1, OPB_I_IMM, ALU_ADD, 5'd4));
        a = enc_b(13'd16, 5'd7, 5'd6, 3'b000);
        b = enc_i(12'd4, 5'd9, 3'b010, 5'd8, OP_LOAD);
        run_pair(a, b, 1'b1, exp_ctrl(a, F_VALID | F_COND, OPA_PC, OPB_B_IMM, ALU_ADD, 5'd0),
                 exp_ctrl(b, F_VALID | F_RDMEM, OPA_RS1, OPB_I_IMM, ALU_ADD, 5'd8));
        a = enc_s(12'd8, 5'd10, 5'd11, 3'b010);
        b = enc_r(F7_BASE, 5'd2, 5'd1, F3_OR, 5'd3);
        run_pair(a, b, 1'b0,
                 exp_ctrl(a, F_VALID | F_WRMEM, OPA_RS1, OPB_S_IMM, ALU_ADD, 5'd0),
                 exp_ctrl(b, 8'h00, OPA_RS1, OPB_RS2, ALU_ADD, 5'd0));
        end_test("flow_mem_decode");
    endtask

    task automatic system_decode();
        inst_t a;
        inst_t b;
        start_test();
        a = enc_i(12'h300, 5'd13, F3_CSRRW, 5'd12, OP_SYSTEM);
        b = WFI_INST;
        run_pair(a, b, 1'b1, exp_ctrl(a, F_VALID | F_CSR, OPA_RS1, OPB_RS2, ALU_ADD, 5'd0),
                 exp_ctrl(b, F_VALID | F_HALT, OPA_RS1, OPB_RS2, ALU_ADD, 5'd0));
        a = 32'h0;
        b = enc_i(12'd1, 5'd2, F3_ADD, 5'd3, OP_IMM);
        run_pair(a, b, 1'b0, exp_ctrl(a, F_ILLEGAL, OPA_RS1, OPB_RS2, ALU_ADD, 5'd0),
                 exp_ctrl(b, 8'h00, OPA_RS1, OPB_RS2, ALU_ADD, 5'd0));
        end_test("system_decode");
    endtask

    task automatic group_split();
        fetch_lane_t [ISSUE_WIDTH-1:0] lanes;
        issue_lane_t [ISSUE_WIDTH-1:0] got;
        inst_t a;
        inst_t b;
        start_test();
        a = enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd5);
        b = enc_i(12'd1, 5'd5, F3_ADD, 5'd7, OP_IMM);
        lanes[0] = fetch_lane(1'b1, a);
        lanes[1] = fetch_lane(1'b1, b);
        send_group(lanes);
        #1;
        checks++;
        if (in_ready !== 1'b0) begin
            $display("FAIL %0t: in_ready high while the tail is pending", $time);
            errors++;
        end
        collect(got);
        check_lane(0, got[0], exp_ctrl(a, F_VALID, OPA_RS1, OPB_RS2, ALU_ADD, 5'd5), lanes[0]);
        if (got[1].ctrl.valid !== 1'b0) begin
            $display("FAIL %0t: lane 1 issued with lane 0 in the first part", $time);
            errors++;
        end
        collect(got);
        check_lane(1, got[1], exp_ctrl(b, F_VALID, OPA_RS1, OPB_I_IMM, ALU_ADD, 5'd7),
                   lanes[1]);
        if (got[0].ctrl.valid !== 1'b0) begin
            $display("FAIL %0t: lane 0 issued twice", $time);
            errors++;
        end
        // x0 as destination never splits
        a = enc_i(12'd1, 5'd1, F3_ADD, 5'd0, OP_IMM);
        b = enc_r(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd3);
        run_pair(a, b, 1'b1, exp_ctrl(a, F_VALID, OPA_RS1, OPB_I_IMM, ALU_ADD, 5'd0),
                 exp_ctrl(b, F_VALID, OPA_RS1, OPB_RS2, ALU_ADD, 5'd3));
        end_test("group_split");
    endtask

    task automatic back_pressure();
        fetch_lane_t [ISSUE_WIDTH-1:0] g1;
        fetch_lane_t [ISSUE_WIDTH-1:0] g2;
        issue_lane_t [ISSUE_WIDTH-1:0] snap;
        issue_lane_t [ISSUE_WIDTH-1:0] got;
        start_test();
        g1[0] = fetch_lane(1'b1, enc_r(F7_BASE, 5'd3, 5'd2, F3_ADD, 5'd1));
        g1[1] = fetch_lane(1'b1, enc_r(F7_BASE, 5'd6, 5'd5, F3_XOR, 5'd4));
        g2[0] = fetch_lane(1'b1, enc_r(F7_BASE, 5'd9, 5'd8, F3_OR, 5'd7));
        g2[1] = fetch_lane(1'b1, enc_r(F7_BASE, 5'd12, 5'd11, F3_SLL, 5'd10));
        out_ready = 1'b0;
        send_group(g1);
        snap = out_lanes;
        in_lanes = g2;
        in_valid = 1'b1;
        repeat (5) begin
            #1;
            checks++;
            if (in_ready !== 1'b0 || out_valid !== 1'b1 || out_lanes !== snap) begin
                $display("FAIL %0t: output or in_ready moved under stall", $time);
                errors++;
            end
            @(negedge clk);
        end
        out_ready = 1'b1;
        check_lane(0, snap[0], exp_ctrl(g1[0].inst, F_VALID, OPA_RS1, OPB_RS2, ALU_ADD, 5'd1),
                   g1[0]);
        check_lane(1, snap[1], exp_ctrl(g1[1].inst, F_VALID, OPA_RS1, OPB_RS2, ALU_XOR, 5'd4),
                   g1[1]);
        send_group(g2);
        collect(got);
        check_lane(0, got[0], exp_ctrl(g2[0].inst, F_VALID, OPA_RS1, OPB_RS2, ALU_OR, 5'd7),
                   g2[0]);
        check_lane(1, got[1], exp_ctrl(g2[1].inst, F_VALID, OPA_RS1, OPB_RS2, ALU_SLL, 5'd10),
                   g2[1]);
        end_test("back_pressure");
    endtask

    // --------------------------------------------------
    // run control
    // --------------------------------------------------
    initial begin
        #(N_TESTS * 200 * 40);
        $display("timeout, the tests did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_lanes  = '0;
        out_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        alu_decode();
        flow_mem_decode();
        system_decode();
        group_split();
        back_pressure();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* src/decode_stage.sv */
// superscalar decode stage
// decodes ISSUE_WIDTH lanes per cycle, reads the register file, splits
// a group at the first intra-group RAW and replays the rest one issue
// later; the issued part waits in the ID/EX register for execute
module decode_stage #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    // fetch side
    input  logic                                      in_valid,
    input  decode_pkg::fetch_lane_t [ISSUE_WIDTH-1:0] in_lanes,
    output logic                                      in_ready,
    // register file read ports
    output decode_pkg::reg_idx_t [ISSUE_WIDTH-1:0]    rf_rs1_idx,
    output decode_pkg::reg_idx_t [ISSUE_WIDTH-1:0]    rf_rs2_idx,
    input  decode_pkg::xlen_t [ISSUE_WIDTH-1:0]       rf_rs1_val,
    input  decode_pkg::xlen_t [ISSUE_WIDTH-1:0]       rf_rs2_val,
    // execute side
    input  logic                                      out_ready,
    output logic                                      out_valid,
    output decode_pkg::issue_lane_t [ISSUE_WIDTH-1:0] out_lanes
);
    import decode_pkg::*;

    fetch_lane_t [ISSUE_WIDTH-1:0] src_lanes;
    lane_ctrl_t [ISSUE_WIDTH-1:0]  ctrl;
    issue_lane_t [ISSUE_WIDTH-1:0] load_lanes;
    logic [ISSUE_WIDTH-1:0]        issue_mask;
    logic [ISSUE_WIDTH-1:0]        replay_mask;
    logic                          src_valid;
    logic                          advance;

    replay_buffer #(.ISSUE_WIDTH(ISSUE_WIDTH)) u_replay (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_lanes    (in_lanes),
        .advance     (advance),
        .replay_mask (replay_mask),
        .in_ready    (in_ready),
        .src_valid   (src_valid),
        .src_lanes   (src_lanes)
    );

    // --------------------------------------------------
    // per-lane decode and operand read
    // --------------------------------------------------
    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
        rv32_decoder u_dec (
            .lane (src_lanes[i]),
            .ctrl (ctrl[i])
        );

        assign rf_rs1_idx[i] = ctrl[i].rs1_idx;
        assign rf_rs2_idx[i] = ctrl[i].rs2_idx;

        // lanes held for replay go out as bubbles
        assign load_lanes[i] = '{
            ctrl:      issue_mask[i] ? ctrl[i] : lane_ctrl_t'('0),
            pc:        src_lanes[i].pc,
            inst:      src_lanes[i].inst,
            rs1_value: rf_rs1_val[i],
            rs2_value: rf_rs2_val[i]
        };
    end

    group_hazard #(.ISSUE_WIDTH(ISSUE_WIDTH)) u_hazard (
        .ctrl        (ctrl),
        .issue_mask  (issue_mask),
        .replay_mask (replay_mask)
    );

    issue_reg #(.ISSUE_WIDTH(ISSUE_WIDTH)) u_issue (
        .clk        (clk),
        .arst_n     (arst_n),
        .load_lanes (load_lanes),
        .src_valid  (src_valid),
        .out_ready  (out_ready),
        .advance    (advance),
        .out_valid  (out_valid),
        .out_lanes  (out_lanes)
    );

endmodule

/* src/issue_reg.sv */
// ID/EX register
// holds the issued part of a group for execute and stalls it while
// out_ready is low; advance tells the front end a new load is taken
module issue_reg #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  decode_pkg::issue_lane_t [ISSUE_WIDTH-1:0] load_lanes,
    input  logic                                      src_valid,
    input  logic                                      out_ready,
    output logic                                      advance,
    output logic                                      out_valid,
    output decode_pkg::issue_lane_t [ISSUE_WIDTH-1:0] out_lanes
);

    // --------------------------------------------------
    // handshake
    // --------------------------------------------------
    // free slot or the held packet leaves this edge
    assign advance = ~out_valid | out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= src_valid;
        end
    end

    // --------------------------------------------------
    // payload
    // --------------------------------------------------
    // replayed lanes arrive with valid already cleared
    always_ff @(posedge clk) begin
        if (advance && src_valid) begin
            out_lanes <= load_lanes;
        end
    end

endmodule

/* src/replay_buffer.sv */
// replay buffer
// keeps the unissued tail of a split group and feeds it back to the
// decoders ahead of fetch; fetch is held off while a tail is pending
module replay_buffer #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      in_valid,
    input  decode_pkg::fetch_lane_t [ISSUE_WIDTH-1:0] in_lanes,
    input  logic                                      advance,
    input  logic [ISSUE_WIDTH-1:0]                    replay_mask,
    output logic                                      in_ready,
    output logic                                      src_valid,
    output decode_pkg::fetch_lane_t [ISSUE_WIDTH-1:0] src_lanes
);
    import decode_pkg::*;

    fetch_lane_t [ISSUE_WIDTH-1:0] buf_lanes;
    logic                          pending;

    assign src_valid = pending | in_valid;
    assign in_ready  = advance & ~pending;

    // decode source, buffer wins
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            src_lanes[i] = pending ? buf_lanes[i] : in_lanes[i];
            // fetch lanes count only with in_valid
            if (!pending) begin
                src_lanes[i].valid = in_lanes[i].valid & in_valid;
            end
        end
    end

    // a tail is left whenever the split fires
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (advance) begin
            pending <= |replay_mask;
        end
    end

    // tail lanes only, issued ones invalidated
    always_ff @(posedge clk) begin
        if (advance && (|replay_mask)) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                buf_lanes[i]       <= src_lanes[i];
                buf_lanes[i].valid <= src_lanes[i].valid & replay_mask[i];
            end
        end
    end

endmodule

/* src/group_hazard.sv */
// intra-group hazard split
// finds the first lane that reads a destination written by an earlier
// lane of the same group; that lane and all later ones go to replay
module group_hazard #(
    parameter int ISSUE_WIDTH = 2
) (
    input  decode_pkg::lane_ctrl_t [ISSUE_WIDTH-1:0] ctrl,
    output logic [ISSUE_WIDTH-1:0]                   issue_mask,
    output logic [ISSUE_WIDTH-1:0]                   replay_mask
);

    // lane reads some earlier lane's result
    logic [ISSUE_WIDTH-1:0] reads_earlier;

    always_comb begin
        reads_earlier = '0;
        for (int i = 1; i < ISSUE_WIDTH; i++) begin
            for (int j = 0; j < i; j++) begin
                // raw rs fields, x0 never conflicts
                if (ctrl[i].valid && ctrl[j].dest_idx != '0 &&
                    (ctrl[i].rs1_idx == ctrl[j].dest_idx ||
                     ctrl[i].rs2_idx == ctrl[j].dest_idx)) begin
                    reads_earlier[i] = 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // prefix split
    // --------------------------------------------------
    always_comb begin
        logic split;
        split = 1'b0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            split          = split | reads_earlier[i];
            replay_mask[i] = split;
            issue_mask[i]  = ~split;
        end
    end

endmodule

/* src/rv32_decoder.sv */
// RV32IM instruction decoder
// combinational decode of one fetch lane into datapath controls
// unknown encodings raise illegal and drop valid, WFI raises halt
module rv32_decoder (
    input  decode_pkg::fetch_lane_t lane,
    output decode_pkg::lane_ctrl_t  ctrl
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       writes_rd;

    assign opcode = lane.inst[6:0];
    assign funct3 = lane.inst[14:12];
    assign funct7 = lane.inst[31:25];

    // funct3 to base ALU op, shared by immediate and register forms
    function automatic alu_func_e base_alu(input logic [2:0] f3);
        case (f3)
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SRL:  return ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        // no-op defaults
        ctrl          = '0;
        ctrl.opa      = OPA_RS1;
        ctrl.opb      = OPB_RS2;
        ctrl.alu_func = ALU_ADD;
        writes_rd     = 1'b0;
        if (lane.valid) begin
            case (opcode)
                OP_LUI: begin
                    writes_rd = 1'b1;
                    ctrl.opa  = OPA_ZERO;
                    ctrl.opb  = OPB_U_IMM;
                end
                OP_AUIPC: begin
                    writes_rd = 1'b1;
                    ctrl.opa  = OPA_PC;
                    ctrl.opb  = OPB_U_IMM;
                end
                OP_JAL: begin
                    writes_rd          = 1'b1;
                    ctrl.opa           = OPA_PC;
                    ctrl.opb           = OPB_J_IMM;
                    ctrl.uncond_branch = 1'b1;
                end
                OP_JALR: begin
                    writes_rd          = 1'b1;
                    ctrl.opb           = OPB_I_IMM;
                    ctrl.uncond_branch = 1'b1;
                    ctrl.illegal       = (funct3 != 3'b000);
                end
                OP_BRANCH: begin
                    // beq bne blt bge bltu bgeu
                    ctrl.opa         = OPA_PC;
                    ctrl.opb         = OPB_B_IMM;
                    ctrl.cond_branch = 1'b1;
                    ctrl.illegal     = (funct3 == 3'b010) || (funct3 == 3'b011);
                end
                OP_LOAD: begin
                    // lb lh lw lbu lhu
                    writes_rd    = 1'b1;
                    ctrl.opb     = OPB_I_IMM;
                    ctrl.rd_mem  = 1'b1;
                    ctrl.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
                end
                OP_STORE: begin
                    // sb sh sw
                    ctrl.opb     = OPB_S_IMM;
                    ctrl.wr_mem  = 1'b1;
                    ctrl.illegal = funct3[2] || (funct3[1:0] == 2'b11);
                end
                OP_IMM: begin
                    writes_rd     = 1'b1;
                    ctrl.opb      = OPB_I_IMM;
                    ctrl.alu_func = base_alu(funct3);
                    // shift amounts need a clean upper field
                    if (funct3 == F3_SLL) begin
                        ctrl.illegal = (funct7 != F7_BASE);
                    end else if (funct3 == F3_SRL) begin
                        if (funct7 == F7_ALT) begin
                            ctrl.alu_func = ALU_SRA;
                        end else if (funct7 != F7_BASE) begin
                            ctrl.illegal = 1'b1;
                        end
                    end
                end
                OP_REG: begin
                    writes_rd = 1'b1;
                    case (funct7)
                        F7_BASE: ctrl.alu_func = base_alu(funct3);
                        F7_ALT: begin
                            // only sub and sra use the alternate form
                            if (funct3 == F3_ADD) begin
                                ctrl.alu_func = ALU_SUB;
                            end else if (funct3 == F3_SRL) begin
                                ctrl.alu_func = ALU_SRA;
                            end else begin
                                ctrl.illegal = 1'b1;
                            end
                        end
                        F7_MULDIV: begin
                            // multiply family, divide is not supported
                            case (funct3)
                                3'b000:  ctrl.alu_func = ALU_MUL;
                                3'b001:  ctrl.alu_func = ALU_MULH;
                                3'b010:  ctrl.alu_func = ALU_MULHSU;
                                3'b011:  ctrl.alu_func = ALU_MULHU;
                                default: ctrl.illegal  = 1'b1;
                            endcase
                        end
                        default: ctrl.illegal = 1'b1;
                    endcase
                end
                OP_SYSTEM: begin
                    if (lane.inst == WFI_INST) begin
                        ctrl.halt = 1'b1;
                    end else if (funct3 == F3_CSRRW || funct3 == F3_CSRRS ||
                                 funct3 == F3_CSRRC) begin
                        ctrl.csr_op = 1'b1;
                    end else begin
                        ctrl.illegal = 1'b1;
                    end
                end
                default: ctrl.illegal = 1'b1;
            endcase
        end
        ctrl.valid   = lane.valid & ~ctrl.illegal;
        // raw source fields, used or not
        ctrl.rs1_idx = lane.inst[19:15];
        ctrl.rs2_idx = lane.inst[24:20];
        // x0 stands for no destination
        ctrl.dest_idx = (writes_rd && ctrl.valid) ? lane.inst[11:7] : '0;
    end

endmodule

/* src/decode_pkg.sv */
// decode package
// widths, RV32IM opcode and funct constants, operand select and
// ALU function encodings, and the lane structs of the decode stage
package decode_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int XLEN = 32;

    typedef logic [31:0]     inst_t;
    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;

    // --------------------------------------------------
    // opcodes and funct fields
    // --------------------------------------------------
    // major opcodes in inst[6:0]
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // funct3 of the integer ALU ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of the CSR accesses
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    // funct7 variants
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // wait for interrupt, treated as halt
    localparam inst_t WFI_INST = 32'h1050_0073;

    // --------------------------------------------------
    // select and function codes
    // --------------------------------------------------
    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} opa_sel_e;

    typedef enum logic [2:0] {
        OPB_RS2, OPB_I_IMM, OPB_S_IMM, OPB_B_IMM, OPB_U_IMM, OPB_J_IMM
    } opb_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
    } alu_func_e;

    // --------------------------------------------------
    // lane structs
    // --------------------------------------------------
    // one lane from fetch
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } fetch_lane_t;

    // decoded controls of one lane
    typedef struct packed {
        logic      valid;
        logic      illegal;
        logic      halt;
        logic      csr_op;
        logic      rd_mem;
        logic      wr_mem;
        logic      cond_branch;
        logic      uncond_branch;
        opa_sel_e  opa;
        opb_sel_e  opb;
        alu_func_e alu_func;
        reg_idx_t  dest_idx;
        reg_idx_t  rs1_idx;
        reg_idx_t  rs2_idx;
    } lane_ctrl_t;

    // one lane in the ID/EX register
    typedef struct packed {
        lane_ctrl_t ctrl;
        xlen_t      pc;
        inst_t      inst;
        xlen_t      rs1_value;
        xlen_t      rs2_value;
    } issue_lane_t;

endpackage
